// File: Makefile
SIM  := obj_dir/Vtb_rfid_receive
SRCS := $(shell grep -v '^+' rfid_receive.f) verif/rfid_frames.svh

.PHONY: all run clean

all: run

$(SIM): rfid_receive.f $(SRCS)
	verilator --binary -sv --top-module tb_rfid_receive -f rfid_receive.f -o Vtb_rfid_receive

run: $(SIM)
	-./$(SIM) > sim.log 2>&1
	@cat sim.log
	@if grep -q "Simulation finished: FAIL" sim.log; then \
		echo "Run failed, see sim.log"; exit 1; fi
	@if ! grep -q "Simulation finished: PASS" sim.log; then \
		echo "No pass verdict in sim.log"; exit 1; fi
	@echo "Run passed"

clean:
	rm -rf obj_dir sim.log

// File: rfid_receive.f
+incdir+verif
rtl/rfid_rx_pkg.sv
rtl/rfid_cmd_fsm.sv
rtl/rfid_packet_asm.sv
rtl/rfid_receive.sv
verif/tb_rfid_receive.sv

// File: rtl/rfid_cmd_fsm.sv
`timescale 1ns/1ps

module rfid_cmd_fsm
(
  input  logic                    UL_clock,
  input  logic                    reset_n,
  input  logic                    UL_data,
  output rfid_rx_pkg::frame_pos_t pos,
  output logic                    capture,
  output logic                    packet_rdy,
  output rfid_rx_pkg::op_class_e  op_size
);

  import rfid_rx_pkg::*;

  // Prefix tree states, named after the bits seen so far.
  typedef enum logic [3:0]
  {
    ST_ROOT,
    ST_0,
    ST_1,
    ST_10,
    ST_100,
    ST_11,
    ST_110,
    ST_1100,
    ST_11000,
    ST_110000,
    ST_1100000,
    ST_BODY,
    ST_LOCK
  } state_e;

  state_e               state_q;
  state_e               state_d;
  cmd_e                 cmd_q;
  cmd_e                 cmd_d;
  logic                 body_entry;
  logic [BIT_IDX_W-1:0] index_q;
  logic [BIT_IDX_W-1:0] last_idx_q;
  logic                 frame_end;

  assign capture   = (state_q != ST_LOCK); // Silent once locked.
  assign frame_end = (state_q == ST_BODY) && (index_q == last_idx_q);

  assign pos.index = index_q;
  assign pos.last  = frame_end;

  // Walks the prefix one bit per cycle.
  always_comb
  begin
    state_d    = state_q;
    cmd_d      = cmd_q;
    body_entry = 1'b0;
    case (state_q)
      ST_ROOT:
      begin
        state_d = UL_data ? ST_1 : ST_0;
      end
      ST_0:
      begin
        cmd_d      = UL_data ? CMD_ACK : CMD_QUERY_REP;
        state_d    = ST_BODY;
        body_entry = 1'b1;
      end
      ST_1:
      begin
        state_d = UL_data ? ST_11 : ST_10;
      end
      ST_10:
      begin
        state_d = UL_data ? ST_LOCK : ST_100; // 101 is unknown.
      end
      ST_100:
      begin
        cmd_d      = UL_data ? CMD_QUERY_ADJUST : CMD_QUERY;
        state_d    = ST_BODY;
        body_entry = 1'b1;
      end
      ST_11:
      begin
        state_d = UL_data ? ST_LOCK : ST_110;
      end
      ST_110:
      begin
        state_d = UL_data ? ST_LOCK : ST_1100;
      end
      ST_1100:
      begin
        state_d = UL_data ? ST_LOCK : ST_11000;
      end
      ST_11000:
      begin
        state_d = UL_data ? ST_LOCK : ST_110000;
      end
      ST_110000:
      begin
        state_d = UL_data ? ST_LOCK : ST_1100000;
      end
      ST_1100000:
      begin
        // Only 11000001 survives here.
        if (UL_data)
        begin
          cmd_d      = CMD_REQ_RN;
          state_d    = ST_BODY;
          body_entry = 1'b1;
        end
        else
        begin
          state_d = ST_LOCK;
        end
      end
      ST_BODY:
      begin
        if (frame_end)
        begin
          state_d = ST_ROOT; // Next bit starts a new frame.
        end
      end
      ST_LOCK:
      begin
        state_d = ST_LOCK; // Held until reset.
      end
      default:
      begin
        state_d = ST_LOCK;
      end
    endcase
  end

  always_ff @(posedge UL_clock or negedge reset_n)
  begin
    if (!reset_n)
    begin
      state_q <= ST_ROOT;
    end
    else
    begin
      state_q <= state_d;
    end
  end

  // Command and its last bit index, kept for the body.
  always_ff @(posedge UL_clock or negedge reset_n)
  begin
    if (!reset_n)
    begin
      cmd_q      <= CMD_QUERY_REP;
      last_idx_q <= LEN_QUERY_REP - BIT_IDX_W'(1);
    end
    else if (body_entry)
    begin
      cmd_q      <= cmd_d;
      last_idx_q <= cmd_len(cmd_d) - BIT_IDX_W'(1);
    end
  end

  // Shared bit counter.
  always_ff @(posedge UL_clock or negedge reset_n)
  begin
    if (!reset_n)
    begin
      index_q <= '0;
    end
    else if (capture)
    begin
      if (frame_end)
      begin
        index_q <= '0;
      end
      else
      begin
        index_q <= index_q + BIT_IDX_W'(1);
      end
    end
  end

  // Completion pulse and size class, on the last-bit edge.
  always_ff @(posedge UL_clock or negedge reset_n)
  begin
    if (!reset_n)
    begin
      packet_rdy <= 1'b0;
      op_size    <= OP_SHORT;
    end
    else
    begin
      packet_rdy <= frame_end;
      if (frame_end)
      begin
        op_size <= cmd_class(cmd_q);
      end
    end
  end

endmodule

// File: rtl/rfid_packet_asm.sv
`timescale 1ns/1ps

module rfid_packet_asm
(
  input  logic                              UL_clock,
  input  logic                              reset_n,
  input  logic                              UL_data,
  input  rfid_rx_pkg::frame_pos_t           pos,
  input  logic                              capture,
  output logic [rfid_rx_pkg::PACKET_W-1:0]  packet
);

  import rfid_rx_pkg::*;

  logic [PACKET_W-1:0] work_q;
  logic [PACKET_W-1:0] work_d;

  // Current bit lands MSB-first.
  always_comb
  begin
    if (pos.index == '0)
    begin
      work_d = '0; // Fresh frame.
    end
    else
    begin
      work_d = work_q;
    end
    work_d[PACKET_W - 1 - int'(pos.index)] = UL_data;
  end

  always_ff @(posedge UL_clock)
  begin
    if (capture)
    begin
      work_q <= work_d;
    end
  end

  // Published copy, changes only when a frame completes.
  always_ff @(posedge UL_clock or negedge reset_n)
  begin
    if (!reset_n)
    begin
      packet <= '0;
    end
    else if (capture && pos.last)
    begin
      packet <= work_d; // Includes the final bit.
    end
  end

endmodule

// File: rtl/rfid_receive.sv
`timescale 1ns/1ps

module rfid_receive
(
  input  logic                              UL_clock,
  input  logic                              reset_n,
  input  logic                              UL_data,
  output logic [rfid_rx_pkg::PACKET_W-1:0]  packet,
  output logic                              packet_rdy,
  output rfid_rx_pkg::op_class_e            op_size
);

  import rfid_rx_pkg::*;

  frame_pos_t pos;
  logic       capture;

  // Command decode and frame timing.
  rfid_cmd_fsm u_cmd_fsm
  (
    .UL_clock   (UL_clock),
    .reset_n    (reset_n),
    .UL_data    (UL_data),
    .pos        (pos),
    .capture    (capture),
    .packet_rdy (packet_rdy),
    .op_size    (op_size)
  );

  // Bit placement into the packet.
  rfid_packet_asm u_packet_asm
  (
    .UL_clock (UL_clock),
    .reset_n  (reset_n),
    .UL_data  (UL_data),
    .pos      (pos),
    .capture  (capture),
    .packet   (packet)
  );

endmodule

// File: rtl/rfid_rx_pkg.sv
package rfid_rx_pkg;

  // Packet and frame index widths.
  localparam int PACKET_W  = 64;
  localparam int BIT_IDX_W = 6;

  // Downlink commands the receiver recognizes.
  typedef enum logic [2:0]
  {
    CMD_QUERY_REP,
    CMD_ACK,
    CMD_QUERY,
    CMD_QUERY_ADJUST,
    CMD_REQ_RN
  } cmd_e;

  // Size class reported with each packet.
  typedef enum logic [1:0]
  {
    OP_SHORT  = 2'd0,
    OP_QUERY  = 2'd1,
    OP_ACCESS = 2'd2
  } op_class_e;

  // Total frame lengths, prefix included.
  localparam logic [BIT_IDX_W-1:0] LEN_QUERY_REP    = BIT_IDX_W'(4);
  localparam logic [BIT_IDX_W-1:0] LEN_ACK          = BIT_IDX_W'(18);
  localparam logic [BIT_IDX_W-1:0] LEN_QUERY        = BIT_IDX_W'(22);
  localparam logic [BIT_IDX_W-1:0] LEN_QUERY_ADJUST = BIT_IDX_W'(9);
  localparam logic [BIT_IDX_W-1:0] LEN_REQ_RN       = BIT_IDX_W'(40);

  // Position of the bit currently on the line.
  typedef struct packed
  {
    logic [BIT_IDX_W-1:0] index; // Zero at the first frame bit.
    logic                 last;  // Bit closes the frame.
  } frame_pos_t;

  function automatic logic [BIT_IDX_W-1:0] cmd_len(input cmd_e cmd);
    case (cmd)
      CMD_QUERY_REP:    return LEN_QUERY_REP;
      CMD_ACK:          return LEN_ACK;
      CMD_QUERY:        return LEN_QUERY;
      CMD_QUERY_ADJUST: return LEN_QUERY_ADJUST;
      CMD_REQ_RN:       return LEN_REQ_RN;
      default:          return LEN_QUERY_REP;
    endcase
  endfunction

  function automatic op_class_e cmd_class(input cmd_e cmd);
    case (cmd)
      CMD_QUERY_REP,
      CMD_ACK:          return OP_SHORT;
      CMD_QUERY,
      CMD_QUERY_ADJUST: return OP_QUERY;
      CMD_REQ_RN:       return OP_ACCESS;
      default:          return OP_SHORT;
    endcase
  endfunction

endpackage

// File: verif/rfid_frames.svh
`ifndef RFID_FRAMES_SVH
`define RFID_FRAMES_SVH

// Each row holds kind, prefix bits (right-aligned), prefix length,
// total cycles on the line, and the expected size class.
// Bits after the prefix are random. A reset row drives reset for its length.

localparam int NUM_ROWS     = 21;
localparam int RESET_CYCLES = 16;

typedef enum logic [1:0]
{
  ROW_RESET,
  ROW_FRAME,
  ROW_LOCK
} row_kind_e;

typedef struct packed
{
  row_kind_e            kind;
  logic [7:0]           prefix;
  logic [3:0]           prefix_len;
  logic [6:0]           length;
  rfid_rx_pkg::op_class_e op_class;
} frame_row_t;

frame_row_t frame_table [NUM_ROWS];

task automatic load_frame_table();
  frame_table[0]  = '{ROW_RESET, 8'h00, 4'd0, 7'(RESET_CYCLES), OP_SHORT};
  // One of each command.
  frame_table[1]  = '{ROW_FRAME, 8'h00, 4'd2, 7'd4,  OP_SHORT};  // QueryRep.
  frame_table[2]  = '{ROW_FRAME, 8'h01, 4'd2, 7'd18, OP_SHORT};  // ACK.
  frame_table[3]  = '{ROW_FRAME, 8'h08, 4'd4, 7'd22, OP_QUERY};  // Query.
  frame_table[4]  = '{ROW_FRAME, 8'h09, 4'd4, 7'd9,  OP_QUERY};  // QueryAdjust.
  frame_table[5]  = '{ROW_FRAME, 8'hc1, 4'd8, 7'd40, OP_ACCESS}; // Req_RN.
  // Mixed order with back-to-back short frames.
  frame_table[6]  = '{ROW_FRAME, 8'h09, 4'd4, 7'd9,  OP_QUERY};
  frame_table[7]  = '{ROW_FRAME, 8'h00, 4'd2, 7'd4,  OP_SHORT};
  frame_table[8]  = '{ROW_FRAME, 8'h00, 4'd2, 7'd4,  OP_SHORT};
  frame_table[9]  = '{ROW_FRAME, 8'hc1, 4'd8, 7'd40, OP_ACCESS};
  frame_table[10] = '{ROW_FRAME, 8'h01, 4'd2, 7'd18, OP_SHORT};
  frame_table[11] = '{ROW_FRAME, 8'h08, 4'd4, 7'd22, OP_QUERY};
  // Unknown prefix 1011, then frames that must stay silent.
  frame_table[12] = '{ROW_LOCK,  8'h0b, 4'd4, 7'd8,  OP_SHORT};
  frame_table[13] = '{ROW_FRAME, 8'h01, 4'd2, 7'd18, OP_SHORT};
  frame_table[14] = '{ROW_FRAME, 8'h00, 4'd2, 7'd4,  OP_SHORT};
  frame_table[15] = '{ROW_RESET, 8'h00, 4'd0, 7'(RESET_CYCLES), OP_SHORT};
  // Recovery after the second reset.
  frame_table[16] = '{ROW_FRAME, 8'h00, 4'd2, 7'd4,  OP_SHORT};
  frame_table[17] = '{ROW_FRAME, 8'hc1, 4'd8, 7'd40, OP_ACCESS};
  // Unknown prefix 11001 ends the run locked.
  frame_table[18] = '{ROW_LOCK,  8'h19, 4'd5, 7'd10, OP_SHORT};
  frame_table[19] = '{ROW_FRAME, 8'h09, 4'd4, 7'd9,  OP_QUERY};
  frame_table[20] = '{ROW_FRAME, 8'hc1, 4'd8, 7'd40, OP_ACCESS};
endtask

// Every row occupies its length in cycles.
function automatic int unsigned total_cycles();
  int unsigned sum;
  sum = 0;
  for (int r = 0; r < NUM_ROWS; r++)
  begin
    sum += 32'(frame_table[r].length);
  end
  return sum;
endfunction

`endif

// File: verif/tb_rfid_receive.sv
`timescale 1ns/1ps

module tb_rfid_receive;

  import rfid_rx_pkg::*;

  `include "rfid_frames.svh"

  typedef struct packed
  {
    logic [PACKET_W-1:0] packet;
    op_class_e           op_class;
    logic [31:0]         due;      // Cycle at which the pulse is seen.
  } expect_t;

  logic                UL_clock;
  logic                reset_n;
  logic                UL_data;
  logic [PACKET_W-1:0] packet;
  logic                packet_rdy;
  op_class_e           op_size;

  expect_t             exp_q[$];
  int unsigned         cycle = 0;
  int unsigned         cycle_limit = 0;
  logic                locked = 1'b0;
  logic                prev_rdy = 1'b0;
  logic [PACKET_W-1:0] last_packet = '0;
  op_class_e           last_class = OP_SHORT;

  rfid_receive DUT
  (
    .UL_clock   (UL_clock),
    .reset_n    (reset_n),
    .UL_data    (UL_data),
    .packet     (packet),
    .packet_rdy (packet_rdy),
    .op_size    (op_size)
  );

  initial
  begin
    UL_clock = 1'b0;
    forever #5 UL_clock = ~UL_clock;
  end

  task automatic fail_run(input string why);
    $display("%s", why);
    $display("Simulation finished: FAIL");
    $fatal(1);
  endtask

  task automatic check_value(input string name, input logic [63:0] actual,
                             input logic [63:0] expected);
    if (actual !== expected)
    begin
      fail_run($sformatf("[FAIL] %s: actual 0x%h, expected 0x%h", name, actual, expected));
    end
  endtask

  task automatic drive_cycle(input logic data, input logic rst_n);
    @(posedge UL_clock);
    #1;
    reset_n = rst_n;
    UL_data = data;
  endtask

  task automatic send_row(input frame_row_t row);
    logic [PACKET_W-1:0] exp_pkt;
    logic                bit_val;
    logic [31:0]         rnd;
    expect_t             entry;
    exp_pkt = '0;
    if (row.kind == ROW_RESET)
    begin
      for (int i = 0; i < int'(row.length); i++)
      begin
        drive_cycle(1'b0, 1'b0);
      end
      locked = 1'b0;
    end
    else
    begin
      for (int i = 0; i < int'(row.length); i++)
      begin
        rnd = $urandom;
        bit_val = (i < int'(row.prefix_len)) ? row.prefix[int'(row.prefix_len) - 1 - i] : rnd[0];
        exp_pkt[PACKET_W - 1 - i] = bit_val; // Left-aligned.
        drive_cycle(bit_val, 1'b1);
      end
      if (row.kind == ROW_LOCK)
      begin
        locked = 1'b1;
      end
      else if (!locked)
      begin
        entry.packet   = exp_pkt;
        entry.op_class = row.op_class;
        entry.due      = 32'(cycle + 1);
        exp_q.push_back(entry);
      end
    end
  endtask

  always @(posedge UL_clock)
  begin
    cycle <= cycle + 1;
    if (cycle >= cycle_limit)
    begin
      fail_run("Timeout: the run went past its cycle limit.");
    end
  end

  // Monitor at the falling edge, where outputs are settled.
  always @(negedge UL_clock)
  begin
    expect_t head;
    logic    was_high;
    was_high = prev_rdy;
    prev_rdy = packet_rdy;
    if (!reset_n)
    begin
      check_value("packet_rdy", 64'(packet_rdy), 64'd0);
      check_value("packet", packet, 64'd0);
      check_value("op_size", 64'(op_size), 64'(OP_SHORT));
      last_packet = '0;
      last_class  = OP_SHORT;
    end
    else if (packet_rdy)
    begin
      if (was_high)
      begin
        fail_run("packet_rdy stayed high for two cycles in a row.");
      end
      else if (exp_q.size() == 0)
      begin
        fail_run("packet_rdy pulsed with no completed frame pending.");
      end
      else
      begin
        head = exp_q.pop_front();
        check_value("pulse cycle", 64'(cycle), 64'(head.due));
        check_value("packet", packet, head.packet);
        check_value("op_size", 64'(op_size), 64'(head.op_class));
        last_packet = packet;
        last_class  = op_size;
      end
    end
    else if (exp_q.size() != 0 && exp_q[0].due < cycle)
    begin
      fail_run("packet_rdy never pulsed for a completed frame.");
    end
    else
    begin
      check_value("packet", packet, last_packet); // Held between pulses.
      check_value("op_size", 64'(op_size), 64'(last_class));
    end
  end

  initial
  begin
    reset_n  = 1'b0;
    UL_data  = 1'b0;
    void'($urandom(32'h92f5));
    load_frame_table();
    cycle_limit = total_cycles() + 200;
    for (int r = 0; r < NUM_ROWS; r++)
    begin
      send_row(frame_table[r]);
    end
    repeat (4) @(posedge UL_clock);
    if (exp_q.size() != 0)
    begin
      fail_run("Run ended with expected packets still pending.");
    end
    else
    begin
      $display("Simulation finished: PASS");
      $finish;
    end
  end

endmodule
